/* vlog.f */
common/bridge_pkg.sv
logic/axil_client.sv
logic/dram_hash_decode.sv
memory/mem_bank_array.sv
logic/axil_responder.sv
logic/axil_io_bridge.sv
tests/tb_axil_io_bridge_asserts.sv
tests/tb_axil_io_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AXI-Lite bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_axil_io_bridge \
   -f vlog.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST PASS" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tests/tb_axil_io_bridge.sv */
// Directed and random AXI-Lite traffic, checked in order against a 256-word model.
// Only one of AW+W or AR is offered at a time.
`default_nettype none

module tb_axil_io_bridge;

   import bridge_pkg::*;

   localparam int          CLK_PERIOD = 40;
   localparam int          RAND_TXNS  = 200;
   localparam int          TXN_COUNT  = RAND_TXNS + 42;
   localparam logic [31:0] SEED       = 32'h4496_7703;

   logic       clk = 1'b0;
   logic       rst_n;
   axil_addr_t awaddr, araddr;
   axil_data_t wdata, rdata;
   axil_strb_t wstrb;
   axil_resp_t bresp, rresp;
   logic       awvalid, wvalid, arvalid;
   logic       awready, wready, arready, bvalid, rvalid;
   logic       bready = 1'b1;
   logic       rready = 1'b1;
   logic       stall_en = 1'b0;

   axil_data_t  model_mem [256];
   // Entries are {write, response code, read data}
   logic [34:0] expected_q [$];

   always #(CLK_PERIOD/2) clk = ~clk;

   axil_io_bridge dut0
     (.clk_i(clk), .rst_n_i(rst_n)
      , .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready)
      , .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid)
      , .s_axil_wready_o(wready)
      , .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid), .s_axil_bready_i(bready)
      , .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid), .s_axil_arready_o(arready)
      , .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp), .s_axil_rvalid_o(rvalid)
      , .s_axil_rready_i(rready)
      );

   // Reference model, updated on in-range writes
   function automatic logic [34:0] model_access(input logic we, input axil_addr_t addr,
                                                input axil_data_t data, input axil_strb_t strb);
      logic [7:0] word;
      logic       in_range;
      axil_data_t rd;
      word     = addr[9:2];
      in_range = addr < axil_addr_t'(MEM_BYTES);
      rd       = '0;
      if (in_range && we)
      begin
         for (int i = 0; i < 4; i++)
         begin
            if (strb[i])
               model_mem[word][8*i +: 8] = data[8*i +: 8];
         end
      end
      else if (in_range)
         rd = model_mem[word];
      return {we, in_range ? RESP_OKAY : RESP_SLVERR, rd};
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] time %0t: %s is 0x%08h, expected 0x%08h",
                  $time, what, actual, expected);
         $display("TEST FAIL");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic send_txn(input logic we, input axil_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb);
      logic taken;
      awaddr  = addr;
      araddr  = addr;
      wdata   = data;
      wstrb   = strb;
      awvalid = we;
      wvalid  = we;
      arvalid = !we;
      do
      begin
         #(CLK_PERIOD/4);
         taken = we ? (awready && wready) : arready;
         if (taken)
            expected_q.push_back(model_access(we, addr, data, strb));
         @(negedge clk);
      end while (!taken);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
   endtask

   initial
   begin : drive_ready_stalls
      forever
      begin
         @(negedge clk);
         bready = !stall_en || ($urandom % 4 != 0);
         rready = !stall_en || ($urandom % 4 != 0);
      end
   end

   initial
   begin : compare_responses
      logic [34:0] expected;
      forever
      begin
         @(negedge clk);
         #(CLK_PERIOD/4);
         if ((bvalid && bready) || (rvalid && rready))
         begin
            if (expected_q.size() == 0)
            begin
               $display("A B or R response came back with no request outstanding");
               $display("TEST FAIL");
               $fatal(1, "Unexpected response");
            end
            else
            begin
               expected = expected_q.pop_front();
               check_value(32'(bvalid), 32'(expected[34]), "B channel chosen");
               check_value(32'(bvalid ? bresp : rresp), 32'(expected[33:32]), "response code");
               if (rvalid)
                  check_value(rdata, expected[31:0], "rdata");
            end
         end
      end
   end

   initial
   begin : watchdog
      #(TXN_COUNT * 50 * CLK_PERIOD);
      $display("Timeout: the bridge did not finish all transactions in time");
      $display("TEST FAIL");
      $fatal(1, "Watchdog expired");
   end

   initial
   begin : run_tests
      axil_addr_t addr;
      void'($urandom(SEED));
      rst_n   = 1'b0;
      awaddr  = '0;
      araddr  = '0;
      wdata   = '0;
      wstrb   = '0;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
      for (int i = 0; i < 256; i++)
         model_mem[i] = '0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      check_value(32'(awready), 32'd0, "awready after reset");
      check_value(32'(wready), 32'd0, "wready after reset");
      check_value(32'(arready), 32'd0, "arready after reset");
      check_value(32'(bvalid), 32'd0, "bvalid after reset");
      check_value(32'(rvalid), 32'd0, "rvalid after reset");
      repeat (4) @(negedge clk);

      send_txn(1'b1, 32'h10, 32'hCAFE_0123, 4'hF);
      send_txn(1'b0, 32'h10, '0, '0);
      send_txn(1'b0, 32'h2F0, '0, '0);
      // Merged word after a partial write
      send_txn(1'b1, 32'h40, 32'h1122_3344, 4'hF);
      send_txn(1'b1, 32'h40, 32'hAABB_CCDD, 4'h5);
      send_txn(1'b0, 32'h40, '0, '0);
      // 0x400 lands on word 0 if the range check is missed
      send_txn(1'b1, 32'h400, 32'hDEAD_BEEF, 4'hF);
      send_txn(1'b1, 32'hFFFF_FFFC, 32'hDEAD_BEEF, 4'hF);
      send_txn(1'b0, 32'h400, '0, '0);
      send_txn(1'b0, 32'h0, '0, '0);
      // Word indices 0x40 to 0x4F, same rows in fours with hashed banks
      for (int k = 0; k < 16; k++)
         send_txn(1'b1, axil_addr_t'(256 + 4*k), 32'h5A00_0000 | 32'(k), 4'hF);
      for (int k = 0; k < 16; k++)
         send_txn(1'b0, axil_addr_t'(256 + 4*k), '0, '0);

      stall_en = 1'b1;
      for (int n = 0; n < RAND_TXNS; n++)
      begin
         if ($urandom % 4 == 0)
            addr = axil_addr_t'(MEM_BYTES) + ($urandom % 32'h1000);
         else
            addr = axil_addr_t'(($urandom % 256) * 4);
         send_txn($urandom % 2 == 1, addr, $urandom, axil_strb_t'($urandom % 16));
         repeat ($urandom % 3) @(negedge clk);
      end
      stall_en = 1'b0;

      while (expected_q.size() != 0)
         @(negedge clk);
      // Quiet window so a stray extra response is still caught
      repeat (4) @(negedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/tb_axil_io_bridge_asserts.sv */
// Response channel and reset checks, bound into the bridge top level.
// The reset check expects the AXI valids to be held low during reset.
`default_nettype none

module tb_axil_io_bridge_asserts
  (input  wire                           clk_i
   , input  wire                         rst_n_i
   , input  wire                         awready_i
   , input  wire                         wready_i
   , input  wire                         arready_i
   , input  wire                         bvalid_i
   , input  wire                         bready_i
   , input  wire bridge_pkg::axil_resp_t bresp_i
   , input  wire                         rvalid_i
   , input  wire                         rready_i
   , input  wire bridge_pkg::axil_resp_t rresp_i
   , input  wire bridge_pkg::axil_data_t rdata_i
   , input  wire                         cmd_valid_i
   , input  wire                         hash_valid_i
   , input  wire                         res_valid_i
   );

   assert property (@(posedge clk_i) disable iff (!rst_n_i) !(bvalid_i && rvalid_i))
      else $error("bvalid and rvalid are high together");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
      else $error("B response dropped or changed before bready");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
      else $error("R response dropped or changed before rready");

   // From the second reset edge on, the first one has cleared every stage
   assert property (@(posedge clk_i) !rst_n_i && $past(!rst_n_i) |->
                    !(awready_i || wready_i || arready_i || bvalid_i || rvalid_i
                      || cmd_valid_i || hash_valid_i || res_valid_i))
      else $error("ready or valid high during reset");

endmodule

bind axil_io_bridge tb_axil_io_bridge_asserts u_asserts
  (.clk_i(clk_i), .rst_n_i(rst_n_i)
   , .awready_i(s_axil_awready_o), .wready_i(s_axil_wready_o)
   , .arready_i(s_axil_arready_o)
   , .bvalid_i(s_axil_bvalid_o), .bready_i(s_axil_bready_i), .bresp_i(s_axil_bresp_o)
   , .rvalid_i(s_axil_rvalid_o), .rready_i(s_axil_rready_i), .rresp_i(s_axil_rresp_o)
   , .rdata_i(s_axil_rdata_o)
   , .cmd_valid_i(cmd_valid), .hash_valid_i(hash_valid), .res_valid_i(res_valid)
   );

`default_nettype wire

/* logic/axil_io_bridge.sv */
// AXI-Lite slave into a banked memory, four registered stages deep.
// In-order responses; at most three commands in flight.
`default_nettype none

module axil_io_bridge
  (input  wire                     clk_i
   , input  wire                   rst_n_i

   , input  wire bridge_pkg::axil_addr_t s_axil_awaddr_i
   , input  wire                   s_axil_awvalid_i
   , output logic                  s_axil_awready_o

   , input  wire bridge_pkg::axil_data_t s_axil_wdata_i
   , input  wire bridge_pkg::axil_strb_t s_axil_wstrb_i
   , input  wire                   s_axil_wvalid_i
   , output logic                  s_axil_wready_o

   , output bridge_pkg::axil_resp_t s_axil_bresp_o
   , output logic                  s_axil_bvalid_o
   , input  wire                   s_axil_bready_i

   , input  wire bridge_pkg::axil_addr_t s_axil_araddr_i
   , input  wire                   s_axil_arvalid_i
   , output logic                  s_axil_arready_o

   , output bridge_pkg::axil_data_t s_axil_rdata_o
   , output bridge_pkg::axil_resp_t s_axil_rresp_o
   , output logic                  s_axil_rvalid_o
   , input  wire                   s_axil_rready_i
   );

   import bridge_pkg::*;

   logic       cmd_valid, cmd_ready, cmd_we;
   axil_addr_t cmd_addr;
   axil_data_t cmd_data;
   axil_strb_t cmd_strb;

   logic       hash_valid, hash_ready, hash_we, hash_in_range;
   bank_idx_t  hash_bank;
   row_idx_t   hash_row;
   axil_data_t hash_data;
   axil_strb_t hash_strb;

   logic       res_valid, res_we, res_in_range, slot_free;
   axil_data_t res_data;

   axil_client u_client
     (.clk_i(clk_i), .rst_n_i(rst_n_i)
      , .s_axil_awaddr_i(s_axil_awaddr_i), .s_axil_awvalid_i(s_axil_awvalid_i)
      , .s_axil_awready_o(s_axil_awready_o)
      , .s_axil_wdata_i(s_axil_wdata_i), .s_axil_wstrb_i(s_axil_wstrb_i)
      , .s_axil_wvalid_i(s_axil_wvalid_i), .s_axil_wready_o(s_axil_wready_o)
      , .s_axil_araddr_i(s_axil_araddr_i), .s_axil_arvalid_i(s_axil_arvalid_i)
      , .s_axil_arready_o(s_axil_arready_o)
      , .cmd_valid_o(cmd_valid), .cmd_ready_i(cmd_ready), .cmd_we_o(cmd_we)
      , .cmd_addr_o(cmd_addr), .cmd_data_o(cmd_data), .cmd_strb_o(cmd_strb)
      );

   dram_hash_decode u_hash
     (.clk_i(clk_i), .rst_n_i(rst_n_i)
      , .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_we_i(cmd_we)
      , .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data), .cmd_strb_i(cmd_strb)
      , .hash_valid_o(hash_valid), .hash_ready_i(hash_ready), .hash_we_o(hash_we)
      , .hash_bank_o(hash_bank), .hash_row_o(hash_row), .hash_in_range_o(hash_in_range)
      , .hash_data_o(hash_data), .hash_strb_o(hash_strb)
      );

   mem_bank_array u_mem
     (.clk_i(clk_i), .rst_n_i(rst_n_i)
      , .hash_valid_i(hash_valid), .hash_ready_o(hash_ready), .hash_we_i(hash_we)
      , .hash_bank_i(hash_bank), .hash_row_i(hash_row), .hash_in_range_i(hash_in_range)
      , .hash_data_i(hash_data), .hash_strb_i(hash_strb)
      , .slot_free_i(slot_free)
      , .res_valid_o(res_valid), .res_we_o(res_we), .res_in_range_o(res_in_range)
      , .res_data_o(res_data)
      );

   axil_responder u_resp
     (.clk_i(clk_i), .rst_n_i(rst_n_i)
      , .res_valid_i(res_valid), .res_we_i(res_we), .res_in_range_i(res_in_range)
      , .res_data_i(res_data), .slot_free_o(slot_free)
      , .s_axil_bresp_o(s_axil_bresp_o), .s_axil_bvalid_o(s_axil_bvalid_o)
      , .s_axil_bready_i(s_axil_bready_i)
      , .s_axil_rdata_o(s_axil_rdata_o), .s_axil_rresp_o(s_axil_rresp_o)
      , .s_axil_rvalid_o(s_axil_rvalid_o), .s_axil_rready_i(s_axil_rready_i)
      );

endmodule

`default_nettype wire

/* logic/axil_responder.sv */
// One-entry response holder driving either B or R.
// A result arriving from memory always finds this slot free.
`default_nettype none

module axil_responder
  (input  wire                     clk_i
   , input  wire                   rst_n_i

   , input  wire                   res_valid_i
   , input  wire                   res_we_i
   , input  wire                   res_in_range_i
   , input  wire bridge_pkg::axil_data_t res_data_i
   , output logic                  slot_free_o

   , output bridge_pkg::axil_resp_t s_axil_bresp_o
   , output logic                  s_axil_bvalid_o
   , input  wire                   s_axil_bready_i

   , output bridge_pkg::axil_data_t s_axil_rdata_o
   , output bridge_pkg::axil_resp_t s_axil_rresp_o
   , output logic                  s_axil_rvalid_o
   , input  wire                   s_axil_rready_i
   );

   import bridge_pkg::*;

   logic       bvalid_q;
   logic       rvalid_q;
   axil_resp_t resp_q;
   axil_data_t rdata_q;
   logic       resp_done;

   assign resp_done = (bvalid_q & s_axil_bready_i) | (rvalid_q & s_axil_rready_i);

   // A result already leaving memory claims the slot as well
   assign slot_free_o = (~(bvalid_q | rvalid_q) | resp_done) & ~res_valid_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end
      else if (res_valid_i)
      begin
         bvalid_q <= res_we_i;
         rvalid_q <= ~res_we_i;
      end
      else if (resp_done)
      begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (res_valid_i)
      begin
         resp_q  <= res_in_range_i ? RESP_OKAY : RESP_SLVERR;
         rdata_q <= res_data_i;
      end
   end

   assign s_axil_bvalid_o = bvalid_q;
   assign s_axil_bresp_o  = resp_q;
   assign s_axil_rvalid_o = rvalid_q;
   assign s_axil_rresp_o  = resp_q;
   assign s_axil_rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* memory/mem_bank_array.sv */
// Four banks of BANK_DEPTH words, byte-strobed writes, registered read.
// Reset clears every word; out-of-range accesses touch nothing and read 0.
`default_nettype none

module mem_bank_array
  (input  wire                     clk_i
   , input  wire                   rst_n_i

   , input  wire                   hash_valid_i
   , output logic                  hash_ready_o
   , input  wire                   hash_we_i
   , input  wire bridge_pkg::bank_idx_t hash_bank_i
   , input  wire bridge_pkg::row_idx_t  hash_row_i
   , input  wire                   hash_in_range_i
   , input  wire bridge_pkg::axil_data_t hash_data_i
   , input  wire bridge_pkg::axil_strb_t hash_strb_i

   , input  wire                   slot_free_i

   , output logic                  res_valid_o
   , output logic                  res_we_o
   , output logic                  res_in_range_o
   , output bridge_pkg::axil_data_t res_data_o
   );

   import bridge_pkg::*;

   logic                 access;
   logic [NUM_BANKS-1:0] bank_we;
   axil_data_t           bank_rd [NUM_BANKS];
   logic                 res_valid_q;

   // No buffering here, so the responder slot gates the hash stage
   assign hash_ready_o = slot_free_i;
   assign access       = hash_valid_i & slot_free_i;

   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      axil_data_t words_q [BANK_DEPTH];

      assign bank_we[b] = access & hash_we_i & hash_in_range_i
                          & (hash_bank_i == bank_idx_t'(b));

      always_ff @(posedge clk_i)
      begin
         if (!rst_n_i)
         begin
            for (int r = 0; r < BANK_DEPTH; r++)
               words_q[r] <= '0;
         end
         else if (bank_we[b])
         begin
            for (int i = 0; i < AXIL_STRB_W; i++)
            begin
               if (hash_strb_i[i])
                  words_q[hash_row_i][8*i +: 8] <= hash_data_i[8*i +: 8];
            end
         end
      end

      assign bank_rd[b] = words_q[hash_row_i];
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         res_valid_q <= 1'b0;
      else
         res_valid_q <= access;
   end

   always_ff @(posedge clk_i)
   begin
      if (access)
      begin
         res_we_o       <= hash_we_i;
         res_in_range_o <= hash_in_range_i;
         // Writes and bad addresses return zero data
         if (hash_we_i || !hash_in_range_i)
            res_data_o <= '0;
         else
            res_data_o <= bank_rd[hash_bank_i];
      end
   end

   assign res_valid_o = res_valid_q;

endmodule

`default_nettype wire

/* logic/dram_hash_decode.sv */
// Registers a command with its hashed bank and row.
// Bank is XORed with the low row bits to spread strided accesses.
`default_nettype none

module dram_hash_decode
  (input  wire                     clk_i
   , input  wire                   rst_n_i

   , input  wire                   cmd_valid_i
   , output logic                  cmd_ready_o
   , input  wire                   cmd_we_i
   , input  wire bridge_pkg::axil_addr_t cmd_addr_i
   , input  wire bridge_pkg::axil_data_t cmd_data_i
   , input  wire bridge_pkg::axil_strb_t cmd_strb_i

   , output logic                  hash_valid_o
   , input  wire                   hash_ready_i
   , output logic                  hash_we_o
   , output bridge_pkg::bank_idx_t hash_bank_o
   , output bridge_pkg::row_idx_t  hash_row_o
   , output logic                  hash_in_range_o
   , output bridge_pkg::axil_data_t hash_data_o
   , output bridge_pkg::axil_strb_t hash_strb_o
   );

   import bridge_pkg::*;

   localparam int BYTE_OFS_W = $clog2(AXIL_STRB_W);
   localparam int BANK_W     = $bits(bank_idx_t);
   localparam int WORD_W     = $bits(row_idx_t) + BANK_W;

   logic [WORD_W-1:0] word_idx;
   bank_idx_t         bank_d;
   logic              hash_valid_q;
   logic              take;

   assign word_idx = cmd_addr_i[BYTE_OFS_W +: WORD_W];
   assign bank_d   = word_idx[BANK_W-1:0] ^ word_idx[2*BANK_W-1:BANK_W];

   assign cmd_ready_o = ~hash_valid_q | hash_ready_i;
   assign take        = cmd_valid_i & cmd_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         hash_valid_q <= 1'b0;
      else if (cmd_ready_o)
         hash_valid_q <= cmd_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (take)
      begin
         hash_we_o       <= cmd_we_i;
         hash_bank_o     <= bank_d;
         hash_row_o      <= word_idx[WORD_W-1:BANK_W];
         // Only range check in the design
         hash_in_range_o <= cmd_addr_i < axil_addr_t'(MEM_BYTES);
         hash_data_o     <= cmd_data_i;
         hash_strb_o     <= cmd_strb_i;
      end
   end

   assign hash_valid_o = hash_valid_q;

endmodule

`default_nettype wire

/* logic/axil_client.sv */
// AXI-Lite slave front end with a single command slot.
// Writes need AW and W together and win over AR; no PROT inputs.
`default_nettype none

module axil_client
  (input  wire                     clk_i
   , input  wire                   rst_n_i

   , input  wire bridge_pkg::axil_addr_t s_axil_awaddr_i
   , input  wire                   s_axil_awvalid_i
   , output logic                  s_axil_awready_o

   , input  wire bridge_pkg::axil_data_t s_axil_wdata_i
   , input  wire bridge_pkg::axil_strb_t s_axil_wstrb_i
   , input  wire                   s_axil_wvalid_i
   , output logic                  s_axil_wready_o

   , input  wire bridge_pkg::axil_addr_t s_axil_araddr_i
   , input  wire                   s_axil_arvalid_i
   , output logic                  s_axil_arready_o

   , output logic                  cmd_valid_o
   , input  wire                   cmd_ready_i
   , output logic                  cmd_we_o
   , output bridge_pkg::axil_addr_t cmd_addr_o
   , output bridge_pkg::axil_data_t cmd_data_o
   , output bridge_pkg::axil_strb_t cmd_strb_o
   );

   import bridge_pkg::*;

   logic       cmd_valid_q;
   logic       cmd_we_q;
   axil_addr_t cmd_addr_q;
   axil_data_t cmd_data_q;
   axil_strb_t cmd_strb_q;

   logic slot_open;
   logic wr_offered;
   logic wr_take;
   logic rd_take;

   // Slot is usable if empty or draining this cycle
   assign slot_open  = ~cmd_valid_q | cmd_ready_i;
   assign wr_offered = s_axil_awvalid_i & s_axil_wvalid_i;

   assign wr_take = wr_offered & slot_open;
   // Reads only go when no complete write is waiting
   assign rd_take = s_axil_arvalid_i & ~wr_offered & slot_open;

   assign s_axil_awready_o = wr_take;
   assign s_axil_wready_o  = wr_take;
   assign s_axil_arready_o = rd_take;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         cmd_valid_q <= 1'b0;
      else if (wr_take | rd_take)
         cmd_valid_q <= 1'b1;
      else if (cmd_ready_i)
         cmd_valid_q <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_take)
      begin
         cmd_we_q   <= 1'b1;
         cmd_addr_q <= s_axil_awaddr_i;
         cmd_data_q <= s_axil_wdata_i;
         cmd_strb_q <= s_axil_wstrb_i;
      end
      else if (rd_take)
      begin
         cmd_we_q   <= 1'b0;
         cmd_addr_q <= s_axil_araddr_i;
         cmd_data_q <= '0;
         cmd_strb_q <= '0;
      end
   end

   assign cmd_valid_o = cmd_valid_q;
   assign cmd_we_o    = cmd_we_q;
   assign cmd_addr_o  = cmd_addr_q;
   assign cmd_data_o  = cmd_data_q;
   assign cmd_strb_o  = cmd_strb_q;

endmodule

`default_nettype wire

/* common/bridge_pkg.sv */
// Shared widths and response codes for the AXI-Lite I/O bridge.
// The decoded space is MEM_BYTES and must be NUM_BANKS * BANK_DEPTH words.
`default_nettype none

package bridge_pkg;

   // AXI-Lite bus widths
   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // Memory geometry
   localparam int NUM_BANKS  = 4;
   localparam int BANK_DEPTH = 64;
   localparam int MEM_BYTES  = 1024;

   typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
   typedef logic [AXIL_DATA_W-1:0] axil_data_t;
   typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
   typedef logic [1:0]             axil_resp_t;

   typedef logic [$clog2(NUM_BANKS)-1:0]  bank_idx_t;
   typedef logic [$clog2(BANK_DEPTH)-1:0] row_idx_t;

   // AXI response codes in use
   localparam axil_resp_t RESP_OKAY   = 2'b00;
   localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
